// ==== sim.f ====
source/mips_pkg.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_decode.sv
source/mips_control.sv
source/mips_cpu_bus.sv
testbench/tb_memory.sv
testbench/tb_mips_cpu_bus.sv

// ==== Makefile ====
# Verilator flow for the MIPS bus CPU testbench

VERILATOR ?= verilator
TB_TOP ?= tb_mips_cpu_bus
RTL_TOP ?= mips_cpu_bus
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
RTL_SRCS ?= source/mips_pkg.sv source/mips_regfile.sv source/mips_alu.sv \
            source/mips_decode.sv source/mips_control.sv source/mips_cpu_bus.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_mips_cpu_bus.sv ====
// Testbench for the MIPS bus CPU running hand-assembled programs against a stalling memory
`timescale 1ns/1ns

module tb_mips_cpu_bus;

    localparam int num_tests = 9;
    localparam int cycles_per_test = 200;
    localparam logic [31:0] boot_addr = 32'hBFC0_0000;
    localparam logic [4:0] r_zero = 5'd0;
    localparam logic [4:0] r_v0 = 5'd2;
    localparam logic [4:0] r_t0 = 5'd8;
    localparam logic [4:0] r_t1 = 5'd9;

    logic clk;
    logic reset;
    logic stall_en;
    logic active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic read;
    logic write;
    logic waitrequest;
    logic [31:0] writedata;
    logic [3:0] byteenable;
    logic [31:0] readdata;

    int errors;
    int checks;
    int prog_len;
    logic held_req;
    logic [31:0] held_addr;

    mips_cpu_bus UUT (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    tb_memory mem_model (
        .clk(clk), .reset(reset), .stall_en(stall_en),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Whole run is bounded by a per-test cycle allowance
    initial begin
        repeat (num_tests * cycles_per_test) @(posedge clk);
        $display("Timeout: CPU did not halt within %0d cycles", num_tests * cycles_per_test);
        $display("TB FAILED");
        $finish;
    end

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] shamt,
                                          input logic [5:0] funct);
        return {6'd0, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Target field keeps address bits 27:2
    function automatic logic [31:0] enc_j(input logic [31:0] dest);
        return {6'd2, dest[27:2]};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] zext16(input logic [15:0] v);
        return {16'h0000, v};
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic new_program();
        mem_model.fill();
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        mem_model.write_word(prog_len, word);
        prog_len++;
    endtask

    // Reset held for three rising edges and driven just after the edge
    task automatic reset_cpu();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    // Falling edge sampling keeps active and v0 away from the clock edge
    task automatic wait_halt();
        while (active !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    // Appends JR $0 so every program halts
    task automatic run_and_check(input string what, input logic [31:0] exp_v0);
        emit(enc_r(r_zero, r_zero, r_zero, 5'd0, mips_pkg::FN_JR));
        reset_cpu();
        wait_halt();
        check_word(what, register_v0, exp_v0);
    endtask

    task automatic test_reset();
        new_program();
        emit(enc_r(r_zero, r_zero, r_zero, 5'd0, mips_pkg::FN_JR));
        reset_cpu();
        @(negedge clk);
        check_word("active after reset", {31'd0, active}, 32'd1);
        check_word("read after reset", {31'd0, read}, 32'd1);
        check_word("write after reset", {31'd0, write}, 32'd0);
        check_word("first fetch address", address, boot_addr);
        wait_halt();
        check_word("v0 after JR $0 only", register_v0, 32'd0);
    endtask

    // t0 = -3, then op v0, t0, imm
    task automatic imm_case(input string what, input logic [5:0] op, input logic [15:0] imm,
                            input logic [31:0] exp_v0);
        new_program();
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_t0, 16'hFFFD));
        emit(enc_i(op, r_t0, r_v0, imm));
        run_and_check(what, exp_v0);
    endtask

    task automatic test_immediates();
        logic [31:0] a;
        a = sext16(16'hFFFD);
        imm_case("LUI", mips_pkg::OP_LUI, 16'h8001, {16'h8001, 16'h0000});
        imm_case("ORI", mips_pkg::OP_ORI, 16'h8F0F, a | zext16(16'h8F0F));
        imm_case("ADDIU negative", mips_pkg::OP_ADDIU, 16'hFFF0, a + sext16(16'hFFF0));
        imm_case("ANDI zero-extends", mips_pkg::OP_ANDI, 16'h8F0F, a & zext16(16'h8F0F));
        imm_case("XORI zero-extends", mips_pkg::OP_XORI, 16'h80FF, a ^ zext16(16'h80FF));
        // Negative rs against a small positive immediate tells signed from unsigned
        imm_case("SLTI signed", mips_pkg::OP_SLTI, 16'h0001,
                 ($signed(a) < $signed(sext16(16'h0001))) ? 32'd1 : 32'd0);
        imm_case("SLTIU sign-extends", mips_pkg::OP_SLTIU, 16'hFFFF,
                 (a < sext16(16'hFFFF)) ? 32'd1 : 32'd0);
        // A write to $zero must not show up in a later read
        new_program();
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_zero, 16'h0007));
        emit(enc_i(mips_pkg::OP_ORI, r_zero, r_v0, 16'h0011));
        run_and_check("write to $zero ignored", zext16(16'h0011));
    endtask

    // t0 = -8, t1 = 19, then one R-type into v0
    task automatic rtype_case(input string what, input logic [4:0] rs, input logic [4:0] rt,
                              input logic [4:0] shamt, input logic [5:0] funct,
                              input logic [31:0] exp_v0);
        new_program();
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_t0, 16'hFFF8));
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_t1, 16'h0013));
        emit(enc_r(rs, rt, r_v0, shamt, funct));
        run_and_check(what, exp_v0);
    endtask

    task automatic test_rtype();
        logic [31:0] a;
        logic [31:0] b;
        a = sext16(16'hFFF8);
        b = sext16(16'h0013);
        rtype_case("ADDU", r_t0, r_t1, 5'd0, mips_pkg::FN_ADDU, a + b);
        rtype_case("SUBU", r_t0, r_t1, 5'd0, mips_pkg::FN_SUBU, a - b);
        rtype_case("AND", r_t0, r_t1, 5'd0, mips_pkg::FN_AND, a & b);
        rtype_case("OR", r_t0, r_t1, 5'd0, mips_pkg::FN_OR, a | b);
        rtype_case("XOR", r_t0, r_t1, 5'd0, mips_pkg::FN_XOR, a ^ b);
        rtype_case("SLT", r_t0, r_t1, 5'd0, mips_pkg::FN_SLT,
                   ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        rtype_case("SLTU", r_t0, r_t1, 5'd0, mips_pkg::FN_SLTU, (a < b) ? 32'd1 : 32'd0);
        // Shifts act on rt
        rtype_case("SLL", r_zero, r_t0, 5'd4, mips_pkg::FN_SLL, {a[27:0], 4'h0});
        rtype_case("SRL", r_zero, r_t0, 5'd4, mips_pkg::FN_SRL, {4'h0, a[31:4]});
        rtype_case("SRA", r_zero, r_t0, 5'd4, mips_pkg::FN_SRA, {{4{a[31]}}, a[31:4]});
    endtask

    task automatic test_memory();
        logic [31:0] value;
        logic [31:0] store_addr;
        value = {16'hCAFE, 16'h0000} | zext16(16'hF00D);
        store_addr = sext16(16'h0210) + sext16(16'hFFF0);
        new_program();
        emit(enc_i(mips_pkg::OP_LUI, r_zero, r_t0, 16'hCAFE));
        emit(enc_i(mips_pkg::OP_ORI, r_t0, r_t0, 16'hF00D));
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_t1, 16'h0210));
        // Negative offset from the base still lands on 0x200
        emit(enc_i(mips_pkg::OP_SW, r_t1, r_t0, 16'hFFF0));
        emit(enc_i(mips_pkg::OP_LW, r_zero, r_v0, 16'h0200));
        run_and_check("LW after SW", value);
        check_word("memory word at 0x200", mem_model.read_word(int'(store_addr[11:2])), value);
    endtask

    // Branch skips one ADDIU, so v0 tells which path ran
    task automatic branch_case(input string what, input logic [5:0] op,
                               input logic [15:0] t1_imm);
        logic taken;
        taken = (op == mips_pkg::OP_BEQ) ? (t1_imm == 16'd5) : (t1_imm != 16'd5);
        new_program();
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_t0, 16'h0005));
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_t1, t1_imm));
        emit(enc_i(op, r_t0, r_t1, 16'h0001));
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_v0, 16'h0011));
        emit(enc_i(mips_pkg::OP_ADDIU, r_v0, r_v0, 16'h0022));
        run_and_check(what, taken ? 32'h22 : 32'h33);
    endtask

    task automatic test_control();
        branch_case("BEQ taken", mips_pkg::OP_BEQ, 16'd5);
        branch_case("BEQ not taken", mips_pkg::OP_BEQ, 16'd6);
        branch_case("BNE taken", mips_pkg::OP_BNE, 16'd6);
        branch_case("BNE not taken", mips_pkg::OP_BNE, 16'd5);
        new_program();
        emit(enc_i(mips_pkg::OP_ADDIU, r_zero, r_v0, 16'h0040));
        emit(enc_j(boot_addr + 32'd12));
        emit(enc_i(mips_pkg::OP_ADDIU, r_v0, r_v0, 16'h0001));
        emit(enc_i(mips_pkg::OP_ADDIU, r_v0, r_v0, 16'h0100));
        run_and_check("J forward", 32'h140);
    endtask

    // Bus rules checked on every falling edge
    always @(negedge clk) begin
        if (!reset && held_req && address !== held_addr) begin
            errors++;
            $display("[ERROR] %0t ns address moved from %08h to %08h under waitrequest",
                     $time, held_addr, address);
        end
        if (!reset && (read || write) && byteenable !== 4'hF) begin
            errors++;
            $display("[ERROR] %0t ns byteenable %h is not all ones", $time, byteenable);
        end
        // Halted core keeps the bus idle
        if (!reset && !active && (read || write)) begin
            errors++;
            $display("[ERROR] %0t ns bus request while halted", $time);
        end
        held_req = !reset && (read || write) && waitrequest;
        held_addr = address;
    end

    initial begin
        reset = 1'b1;
        stall_en = 1'b0;
        errors = 0;
        checks = 0;
        prog_len = 0;
        held_req = 1'b0;
        held_addr = '0;
        test_reset();
        test_immediates();
        test_rtype();
        test_memory();
        test_control();
        // Same programs again with random waitrequest stalls
        @(posedge clk);
        #2 stall_en = 1'b1;
        test_immediates();
        test_rtype();
        test_memory();
        test_control();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_memory.sv ====
// Avalon slave memory model with 1024 words and pseudo-random waitrequest stalls
`timescale 1ns/1ns

module tb_memory (
    input  logic clk,
    input  logic reset,
    input  logic stall_en,
    input  logic [31:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writedata,
    input  logic [3:0] byteenable,
    output logic [31:0] readdata,
    output logic waitrequest
);

    logic [31:0] mem [1024];
    logic [1:0] stall_cnt;
    logic [31:0] lcg_state = 32'd94910;
    logic [31:0] lcg_peek;
    logic [9:0] idx;

    // LCG step, stall lengths are taken from bits 17:16
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Word index, so the reset vector aliases index 0
    assign idx = address[11:2];
    assign lcg_peek = lcg_next(lcg_state);
    assign readdata = mem[idx];
    assign waitrequest = (read || write) && (stall_cnt != 2'd0);

    // New stall count on reset and after each completed request
    always @(posedge clk) begin
        if (reset || ((read || write) && stall_cnt == 2'd0)) begin
            lcg_state <= lcg_peek;
            stall_cnt <= stall_en ? lcg_peek[17:16] : 2'd0;
        end else if (read || write) begin
            stall_cnt <= stall_cnt - 2'd1;
        end
    end

    // Only whole-word writes are modelled
    always @(posedge clk) begin
        if (!reset && write && !waitrequest && byteenable == 4'hF) begin
            mem[idx] = writedata;
        end
    end

    // Pattern mixes in every index bit so stale words are easy to spot
    task automatic fill();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = {6'h3F, i[9:0], 6'h2A, i[9:0]};
        end
    endtask

    task automatic write_word(input int widx, input logic [31:0] data);
        mem[widx] = data;
    endtask

    function automatic logic [31:0] read_word(input int widx);
        return mem[widx];
    endfunction

endmodule

// ==== source/mips_cpu_bus.sv ====
// MIPS CPU top level joining control, decode, register file and ALU to an Avalon master
`timescale 1ns/1ns

module mips_cpu_bus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [mips_pkg::word_w-1:0] register_v0,
    // Avalon master
    output logic [mips_pkg::word_w-1:0] address,
    output logic write,
    output logic read,
    input  logic waitrequest,
    output logic [mips_pkg::word_w-1:0] writedata,
    output logic [3:0] byteenable,
    input  logic [mips_pkg::word_w-1:0] readdata
);

    mips_pkg::instr_t instr;
    mips_pkg::ctrl_t ctrl;
    logic [mips_pkg::word_w-1:0] rs_val;
    logic [mips_pkg::word_w-1:0] rt_val;
    logic [mips_pkg::word_w-1:0] alu_result;
    logic alu_equal;
    logic wr_en;
    logic [mips_pkg::reg_addr_w-1:0] wr_addr;
    logic [mips_pkg::word_w-1:0] wr_data;

    mips_control u_control (
        .clk(clk), .reset(reset), .active(active),
        .address(address), .writedata(writedata), .read(read), .write(write),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata),
        .instr(instr), .ctrl(ctrl), .rs_val(rs_val), .rt_val(rt_val),
        .alu_result(alu_result), .alu_equal(alu_equal),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    mips_decode u_decode (.instr(instr), .ctrl(ctrl));

    // Register reads are addressed straight from rs and rt
    mips_regfile u_regfile (
        .clk(clk), .reset(reset),
        .rs_addr(instr.r.rs), .rt_addr(instr.r.rt),
        .rs_data(rs_val), .rt_data(rt_val),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .v0(register_v0)
    );

    mips_alu u_alu (
        .ctrl(ctrl), .rs_val(rs_val), .rt_val(rt_val),
        .result(alu_result), .equal(alu_equal)
    );

endmodule

// ==== source/mips_control.sv ====
// MIPS multicycle FSM with PC, instruction register, Avalon requests and writeback select
`timescale 1ns/1ns

module mips_control (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [mips_pkg::word_w-1:0] address,
    output logic [mips_pkg::word_w-1:0] writedata,
    output logic read,
    output logic write,
    output logic [3:0] byteenable,
    input  logic waitrequest,
    input  logic [mips_pkg::word_w-1:0] readdata,
    output mips_pkg::instr_t instr,
    input  mips_pkg::ctrl_t ctrl,
    input  logic [mips_pkg::word_w-1:0] rs_val,
    input  logic [mips_pkg::word_w-1:0] rt_val,
    input  logic [mips_pkg::word_w-1:0] alu_result,
    input  logic alu_equal,
    output logic wr_en,
    output logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    output logic [mips_pkg::word_w-1:0] wr_data
);

    mips_pkg::state_t state;
    logic [mips_pkg::word_w-1:0] pc;
    logic [mips_pkg::word_w-1:0] pc_plus4;
    logic [mips_pkg::word_w-1:0] pc_next;
    logic taken;

    assign pc_plus4 = pc + 32'd4;
    assign taken = (ctrl.branch_eq && alu_equal) || (ctrl.branch_ne && !alu_equal);

    // No delay slot so the new PC is used by the very next fetch
    always_comb begin
        if (ctrl.jump_reg) begin
            pc_next = rs_val;
        end else if (ctrl.jump) begin
            pc_next = {pc_plus4[31:28], instr.j.target, 2'b00};
        end else if (taken) begin
            pc_next = pc_plus4 + {ctrl.imm[29:0], 2'b00};
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::FETCH;
            pc <= mips_pkg::reset_vector;
        end else begin
            case (state)
                mips_pkg::FETCH: begin
                    if (!waitrequest) begin
                        state <= mips_pkg::EXEC;
                    end
                end
                mips_pkg::EXEC: begin
                    if (ctrl.mem_read || ctrl.mem_write) begin
                        state <= mips_pkg::MEM;
                    end else begin
                        pc <= pc_next;
                        // A jump to address 0 ends the program
                        state <= (pc_next == '0) ? mips_pkg::HALT : mips_pkg::FETCH;
                    end
                end
                mips_pkg::MEM: begin
                    if (!waitrequest) begin
                        pc <= pc_plus4;
                        state <= mips_pkg::FETCH;
                    end
                end
                default: state <= mips_pkg::HALT;
            endcase
        end
    end

    // Instruction latched when the fetch completes
    always_ff @(posedge clk) begin
        if (state == mips_pkg::FETCH && !waitrequest) begin
            instr <= readdata;
        end
    end

    // Address and data come from held state so they stay put under stall
    assign active = (state != mips_pkg::HALT);
    assign address = (state == mips_pkg::MEM) ? alu_result : pc;
    assign read = (state == mips_pkg::FETCH) || (state == mips_pkg::MEM && ctrl.mem_read);
    assign write = (state == mips_pkg::MEM) && ctrl.mem_write;
    assign writedata = rt_val;
    assign byteenable = 4'b1111;

    // ALU results retire in EXEC, loads retire when MEM completes
    assign wr_en = (state == mips_pkg::EXEC && ctrl.reg_write && !ctrl.mem_read)
        || (state == mips_pkg::MEM && ctrl.reg_write && !waitrequest);
    assign wr_addr = ctrl.dest;
    assign wr_data = (state == mips_pkg::MEM) ? readdata : alu_result;

    a_one_request: assert property (@(posedge clk) disable iff (reset) !(read && write));

    // A stalled request keeps its address into the next cycle
    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address));

    // Once halted the core stays silent until reset
    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        state == mips_pkg::HALT |=> state == mips_pkg::HALT && !read && !write);

endmodule

// ==== source/mips_decode.sv ====
// MIPS instruction decoder producing the control struct from one instruction word
`timescale 1ns/1ns

module mips_decode (
    input  mips_pkg::instr_t instr,
    output mips_pkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = mips_pkg::ALU_PASS_B;
        ctrl.shamt = instr.r.shamt;
        // I-type writes rt
        ctrl.dest = instr.i.rt;
        case (instr.i.op)
            mips_pkg::OP_RTYPE: begin
                // R-type writes rd
                ctrl.dest = instr.r.rd;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR: ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL: begin
                        ctrl.alu_op = mips_pkg::ALU_SLL;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        ctrl.alu_op = mips_pkg::ALU_SRL;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_SRA: begin
                        ctrl.alu_op = mips_pkg::ALU_SRA;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_pkg::FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.jump_reg = 1'b1;
                    end
                    // Unknown function code runs as a no-op
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            // Target bits of the J view are used by the PC logic
            mips_pkg::OP_J: ctrl.jump = 1'b1;
            mips_pkg::OP_BEQ: begin
                ctrl.branch_eq = 1'b1;
                ctrl.imm_signed = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                ctrl.branch_ne = 1'b1;
                ctrl.imm_signed = 1'b1;
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
            mips_pkg::OP_LUI: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                // Logic immediates and LUI are zero-extended
                ctrl.imm_signed = (instr.i.op == mips_pkg::OP_ADDIU)
                    || (instr.i.op == mips_pkg::OP_SLTI)
                    || (instr.i.op == mips_pkg::OP_SLTIU);
                case (instr.i.op)
                    mips_pkg::OP_ADDIU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::OP_SLTI: ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI: ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
                    default: ctrl.alu_op = mips_pkg::ALU_LUI;
                endcase
            end
            mips_pkg::OP_LW, mips_pkg::OP_SW: begin
                // Effective address is rs plus signed offset
                ctrl.alu_op = mips_pkg::ALU_ADD;
                ctrl.use_imm = 1'b1;
                ctrl.imm_signed = 1'b1;
                ctrl.mem_read = (instr.i.op == mips_pkg::OP_LW);
                ctrl.mem_write = (instr.i.op == mips_pkg::OP_SW);
                ctrl.reg_write = (instr.i.op == mips_pkg::OP_LW);
            end
            default: ctrl.reg_write = 1'b0;
        endcase
        ctrl.imm = ctrl.imm_signed ? {{16{instr.i.imm[15]}}, instr.i.imm}
                                   : {16'b0, instr.i.imm};
        // Writes to $zero are dropped here
        if (ctrl.dest == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

endmodule

// ==== source/mips_alu.sv ====
// MIPS ALU for add, subtract, logic, set-less-than, shifts and upper-immediate load
`timescale 1ns/1ns

module mips_alu (
    input  mips_pkg::ctrl_t ctrl,
    input  logic [mips_pkg::word_w-1:0] rs_val,
    input  logic [mips_pkg::word_w-1:0] rt_val,
    output logic [mips_pkg::word_w-1:0] result,
    output logic equal
);

    logic [mips_pkg::word_w-1:0] b_val;
    logic [4:0] sh_amt;

    // Second operand is the extended immediate for I-type
    assign b_val = ctrl.use_imm ? ctrl.imm : rt_val;

    // Shift distance from the shamt field, else the low bits of B
    assign sh_amt = ctrl.use_shamt ? ctrl.shamt : b_val[4:0];

    // Branch compare always works on the two registers
    assign equal = (rs_val == rt_val);

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_ADD: result = rs_val + b_val;
            mips_pkg::ALU_SUB: result = rs_val - b_val;
            mips_pkg::ALU_AND: result = rs_val & b_val;
            mips_pkg::ALU_OR: result = rs_val | b_val;
            mips_pkg::ALU_XOR: result = rs_val ^ b_val;
            mips_pkg::ALU_SLT: begin
                result = {31'b0, $signed(rs_val) < $signed(b_val)};
            end
            mips_pkg::ALU_SLTU: begin
                result = {31'b0, rs_val < b_val};
            end
            // Shifts take rt as the value being shifted
            mips_pkg::ALU_SLL: result = rt_val << sh_amt;
            mips_pkg::ALU_SRL: result = rt_val >> sh_amt;
            mips_pkg::ALU_SRA: begin
                // Arithmetic shift keeps the sign bit
                result = $unsigned($signed(rt_val) >>> sh_amt);
            end
            mips_pkg::ALU_LUI: result = {b_val[15:0], 16'b0};
            mips_pkg::ALU_PASS_B: result = b_val;
            default: result = b_val;
        endcase
    end

endmodule

// ==== source/mips_regfile.sv ====
// MIPS register file with two combinational reads, one synchronous write and $zero fixed
`timescale 1ns/1ns

module mips_regfile (
    input  logic clk,
    input  logic reset,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    output logic [mips_pkg::word_w-1:0] rs_data,
    output logic [mips_pkg::word_w-1:0] rt_data,
    input  logic wr_en,
    input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
    input  logic [mips_pkg::word_w-1:0] wr_data,
    output logic [mips_pkg::word_w-1:0] v0
);

    logic [mips_pkg::word_w-1:0] regs [32];

    // Entry 0 is never written so it keeps its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0 = regs[mips_pkg::reg_v0];

    // $zero must survive every write the core has made since reset
    a_zero_reg: assert property (@(posedge clk) disable iff (reset)
        (rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0));

endmodule

// ==== source/mips_pkg.sv ====
// MIPS CPU shared package with widths, encodings, instruction views, control and FSM types
package mips_pkg;

    // Datapath and register index widths
    localparam int word_w = 32;
    localparam int reg_addr_w = 5;

    // First fetch address after reset
    localparam logic [word_w-1:0] reset_vector = 32'hBFC0_0000;

    // $v0 is brought out at the top level
    localparam logic [reg_addr_w-1:0] reg_v0 = 5'd2;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function field values
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_B
    } alu_op_t;

    // Field layouts of one instruction word
    typedef struct packed {
        opcode_t op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0] shamt;
        funct_t funct;
    } instr_r_t;

    typedef struct packed {
        opcode_t op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef struct packed {
        opcode_t op;
        logic [25:0] target;
    } instr_j_t;

    // Opcode sits in the same bits in every view
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_t;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_t alu_op;
        logic use_imm;
        logic imm_signed;
        logic use_shamt;
        logic reg_write;
        logic [reg_addr_w-1:0] dest;
        logic mem_read;
        logic mem_write;
        logic branch_eq;
        logic branch_ne;
        logic jump;
        logic jump_reg;
        logic [word_w-1:0] imm;
        logic [4:0] shamt;
    } ctrl_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } state_t;

endpackage
